// ==== logic/cmac_link_pkg.sv ====
// link control definitions for the 100G MAC user logic
// bring-up state encoding and the control word sent to the MAC
package cmac_link_pkg;

    // shared by the receive and transmit bring-up machines
    typedef enum logic [2:0] {
        idle         = 3'd0,
        gt_locked    = 3'd1,
        wait_aligned = 3'd2,
        transfer     = 3'd3
    } link_state_e;

    // control bits to the MAC core
    typedef struct packed {
        logic rx_enable;
        logic tx_enable;
        logic tx_send_lfi;   // local fault indication
        logic tx_send_rfi;   // remote fault indication
    } mac_ctl_t;

endpackage

// ==== logic/cmac_stat_pkg.sv ====
// statistics definitions for the 100G MAC user logic
// per-cycle status from the MAC, accumulated counter sets,
// readout selector and the decoded readout word
package cmac_stat_pkg;

    localparam int CNT_W = 32;   // traffic counter width
    localparam int ERR_W = 16;   // error counter width

    // one cycle of receive status
    typedef struct packed {
        logic        good_packets;
        logic [2:0]  total_packets;
        logic [13:0] good_bytes;
        logic [6:0]  total_bytes;
        logic        aligned_err;
        logic [2:0]  bad_code;
        logic [2:0]  bad_fcs;
        logic        bad_preamble;
        logic        bad_sfd;
    } rx_stat_t;

    // one cycle of transmit status
    typedef struct packed {
        logic        good_packets;
        logic        total_packets;
        logic [13:0] good_bytes;
        logic [5:0]  total_bytes;
        logic        ovf;
        logic        unf;
    } tx_stat_t;

    // traffic totals, same layout on both sides
    typedef struct packed {
        logic [CNT_W-1:0] good_packets;
        logic [CNT_W-1:0] total_packets;
        logic [CNT_W-1:0] good_bytes;
        logic [CNT_W-1:0] total_bytes;
    } rx_cnt_t;

    typedef rx_cnt_t tx_cnt_t;

    typedef struct packed {
        logic [ERR_W-1:0] align;
        logic [ERR_W-1:0] code;
        logic [ERR_W-1:0] fcs;
        logic [ERR_W-1:0] preamble;
        logic [ERR_W-1:0] sfd;
    } rx_err_t;

    typedef struct packed {
        logic [ERR_W-1:0] ovf;
        logic [ERR_W-1:0] unf;
    } tx_err_t;

    typedef enum logic [3:0] {
        rx_good_pkts, rx_total_pkts, rx_good_bytes, rx_total_bytes,
        tx_good_pkts, tx_total_pkts, tx_good_bytes, tx_total_bytes,
        err_align_code, err_fcs_preamble, err_sfd, err_ovf_unf
    } stat_sel_e;

    typedef struct packed {
        logic [ERR_W-1:0] hi;
        logic [ERR_W-1:0] lo;
    } err_pair_t;

    // one readout word: a single total or a pair of error counts
    typedef union packed {
        logic [CNT_W-1:0] count;
        err_pair_t        errs;
    } stat_word_u;

endpackage

// ==== logic/link_bringup.sv ====
// receive and transmit bring-up for the 100G MAC
// rx side enables the receiver once out of idle, tx side sends
// local/remote fault until the receiver reports alignment
`timescale 1ns/1ps

module link_bringup import cmac_link_pkg::*; (
    input  logic     gt_txusrclk2,
    input  logic     usr_rx_reset_w,
    input  logic     stat_rx_aligned,
    output mac_ctl_t mac_ctl
);

    link_state_e rx_state;
    link_state_e tx_state;
    logic        reset_done;
    logic        aligned_q;    // seen by both machines
    logic        rx_enable_q;
    logic        tx_enable_q;
    logic        tx_lfi_q;
    logic        tx_rfi_q;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            reset_done <= 1'b0;
            aligned_q  <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            aligned_q  <= stat_rx_aligned;
        end
    end

    // receive side
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_state    <= idle;
            rx_enable_q <= 1'b0;
        end else begin
            case (rx_state)
                idle: begin
                    rx_enable_q <= 1'b0;
                    if (reset_done) rx_state <= gt_locked;
                end
                gt_locked: begin
                    rx_enable_q <= 1'b1;
                    rx_state    <= wait_aligned;
                end
                wait_aligned: if (aligned_q) rx_state <= transfer;
                transfer:     if (!aligned_q) rx_state <= idle;   // lost lock, start over
                default:      rx_state <= idle;
            endcase
        end
    end

    // transmit side
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_state    <= idle;
            tx_enable_q <= 1'b0;
            tx_lfi_q    <= 1'b0;
            tx_rfi_q    <= 1'b0;
        end else begin
            case (tx_state)
                idle: begin
                    tx_enable_q <= 1'b0;
                    tx_lfi_q    <= 1'b0;
                    tx_rfi_q    <= 1'b0;
                    if (reset_done) tx_state <= gt_locked;
                end
                gt_locked: begin
                    tx_enable_q <= 1'b0;
                    tx_lfi_q    <= 1'b1;   // tell the far end we are not up yet
                    tx_rfi_q    <= 1'b1;
                    tx_state    <= wait_aligned;
                end
                wait_aligned: if (aligned_q) tx_state <= transfer;
                transfer: begin
                    tx_enable_q <= 1'b1;
                    tx_lfi_q    <= 1'b0;
                    tx_rfi_q    <= 1'b0;
                    if (!aligned_q) tx_state <= idle;
                end
                default: tx_state <= idle;
            endcase
        end
    end

    assign mac_ctl = '{rx_enable:   rx_enable_q,
                       tx_enable:   tx_enable_q,
                       tx_send_lfi: tx_lfi_q,
                       tx_send_rfi: tx_rfi_q};

    // faults and data must never go out together
    a_no_enable_with_lfi: assert property (@(posedge gt_txusrclk2)
        disable iff (usr_rx_reset_w) !(mac_ctl.tx_enable && mac_ctl.tx_send_lfi))
        else $error("tx_enable and tx_send_lfi high together");

endmodule

// ==== logic/rx_stat_accum.sv ====
// receive statistics accumulators
// 32-bit traffic totals plus one 16-bit counter per error kind,
// an error counter moves by one per cycle the flag is nonzero
`timescale 1ns/1ps

module rx_stat_accum import cmac_stat_pkg::*; (
    input  logic     gt_txusrclk2,
    input  logic     usr_rx_reset_w,
    input  rx_stat_t rx_stat,
    output rx_cnt_t  rx_cnt,
    output rx_err_t  rx_err
);

    // traffic totals
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_cnt <= '0;
        end else begin
            rx_cnt.good_packets  <= rx_cnt.good_packets + CNT_W'(rx_stat.good_packets);
            rx_cnt.total_packets <= rx_cnt.total_packets + CNT_W'(rx_stat.total_packets);
            rx_cnt.good_bytes    <= rx_cnt.good_bytes + CNT_W'(rx_stat.good_bytes);
            rx_cnt.total_bytes   <= rx_cnt.total_bytes + CNT_W'(rx_stat.total_bytes);
        end
    end

    // error events, multi-bit flags count once
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_err <= '0;
        end else begin
            if (rx_stat.aligned_err != '0) begin
                rx_err.align <= rx_err.align + ERR_W'(1);
            end
            if (rx_stat.bad_code != '0) begin
                rx_err.code <= rx_err.code + ERR_W'(1);
            end
            if (rx_stat.bad_fcs != '0) begin
                rx_err.fcs <= rx_err.fcs + ERR_W'(1);
            end
            if (rx_stat.bad_preamble != '0) begin
                rx_err.preamble <= rx_err.preamble + ERR_W'(1);
            end
            if (rx_stat.bad_sfd != '0) begin
                rx_err.sfd <= rx_err.sfd + ERR_W'(1);   // wraps at 16 bits
            end
        end
    end

endmodule

// ==== logic/tx_stat_accum.sv ====
// transmit statistics accumulators
// traffic totals and the overflow / underflow event counts
`timescale 1ns/1ps

module tx_stat_accum import cmac_stat_pkg::*; (
    input  logic     gt_txusrclk2,
    input  logic     usr_rx_reset_w,
    input  tx_stat_t tx_stat,
    output tx_cnt_t  tx_cnt,
    output tx_err_t  tx_err
);

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_cnt <= '0;
        end else begin
            tx_cnt.good_packets  <= tx_cnt.good_packets + CNT_W'(tx_stat.good_packets);
            tx_cnt.total_packets <= tx_cnt.total_packets + CNT_W'(tx_stat.total_packets);
            tx_cnt.good_bytes    <= tx_cnt.good_bytes + CNT_W'(tx_stat.good_bytes);
            tx_cnt.total_bytes   <= tx_cnt.total_bytes + CNT_W'(tx_stat.total_bytes);
        end
    end

    // fifo overflow / underflow pulses from the MAC
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_err <= '0;
        end else begin
            if (tx_stat.ovf) begin
                tx_err.ovf <= tx_err.ovf + ERR_W'(1);
            end
            if (tx_stat.unf) begin
                tx_err.unf <= tx_err.unf + ERR_W'(1);
            end
        end
    end

endmodule

// ==== logic/stat_readout.sv ====
// counter readout port
// one word per request, chosen by the selector, held until the
// reader takes it; a new request is refused while a word is pending
`timescale 1ns/1ps

module stat_readout import cmac_stat_pkg::*; (
    input  logic       gt_txusrclk2,
    input  logic       usr_rx_reset_w,
    input  logic       req_valid,
    input  stat_sel_e  req_sel,
    output logic       req_ready,
    output logic       rsp_valid,
    output stat_word_u rsp_word,
    input  logic       rsp_ready,
    input  rx_cnt_t    rx_cnt,
    input  rx_err_t    rx_err,
    input  tx_cnt_t    tx_cnt,
    input  tx_err_t    tx_err
);

    stat_word_u sel_word;

    // traffic words go through count, error pairs through errs
    always_comb begin
        sel_word = '0;
        case (req_sel)
            rx_good_pkts:     sel_word.count = rx_cnt.good_packets;
            rx_total_pkts:    sel_word.count = rx_cnt.total_packets;
            rx_good_bytes:    sel_word.count = rx_cnt.good_bytes;
            rx_total_bytes:   sel_word.count = rx_cnt.total_bytes;
            tx_good_pkts:     sel_word.count = tx_cnt.good_packets;
            tx_total_pkts:    sel_word.count = tx_cnt.total_packets;
            tx_good_bytes:    sel_word.count = tx_cnt.good_bytes;
            tx_total_bytes:   sel_word.count = tx_cnt.total_bytes;
            err_align_code:   sel_word.errs = '{hi: rx_err.align, lo: rx_err.code};
            err_fcs_preamble: sel_word.errs = '{hi: rx_err.fcs, lo: rx_err.preamble};
            err_sfd:          sel_word.errs = '{hi: rx_err.sfd, lo: '0};
            err_ovf_unf:      sel_word.errs = '{hi: tx_err.ovf, lo: tx_err.unf};
            default:          sel_word.count = '0;   // unused codes read zero
        endcase
    end

    assign req_ready = ~rsp_valid;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rsp_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;   // word taken
        end
    end

    always_ff @(posedge gt_txusrclk2) begin
        if (req_valid && req_ready) rsp_word <= sel_word;   // snapshot at accept
    end

    a_rsp_hold: assert property (@(posedge gt_txusrclk2)
        disable iff (usr_rx_reset_w) (rsp_valid && !rsp_ready) |=> $stable(rsp_word))
        else $error("rsp_word changed under back-pressure");

endmodule

// ==== logic/cmac_ctrl_top.sv ====
// user-side control around the 100G MAC core
// bring-up control plus rx/tx statistics with a register readout
`timescale 1ns/1ps

module cmac_ctrl_top import cmac_link_pkg::*, cmac_stat_pkg::*; (
    input  logic       gt_txusrclk2,
    input  logic       usr_rx_reset_w,
    input  logic       stat_rx_aligned,
    input  rx_stat_t   rx_stat,
    input  tx_stat_t   tx_stat,
    output mac_ctl_t   mac_ctl,
    input  logic       req_valid,
    input  stat_sel_e  req_sel,
    output logic       req_ready,
    output logic       rsp_valid,
    output stat_word_u rsp_word,
    input  logic       rsp_ready
);

    rx_cnt_t rx_cnt;
    rx_err_t rx_err;
    tx_cnt_t tx_cnt;
    tx_err_t tx_err;

    link_bringup i_link_bringup (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .mac_ctl         (mac_ctl)
    );

    rx_stat_accum i_rx_stat_accum (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .rx_stat        (rx_stat),
        .rx_cnt         (rx_cnt),
        .rx_err         (rx_err)
    );

    tx_stat_accum i_tx_stat_accum (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .tx_stat        (tx_stat),
        .tx_cnt         (tx_cnt),
        .tx_err         (tx_err)
    );

    stat_readout i_stat_readout (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .req_valid      (req_valid),
        .req_sel        (req_sel),
        .req_ready      (req_ready),
        .rsp_valid      (rsp_valid),
        .rsp_word       (rsp_word),
        .rsp_ready      (rsp_ready),
        .rx_cnt         (rx_cnt),
        .rx_err         (rx_err),
        .tx_cnt         (tx_cnt),
        .tx_err         (tx_err)
    );

endmodule

// ==== dv/cmac_ctrl_tb_cases.svh ====
// stimulus table for the MAC control testbench
// each entry drives its status for reps cycles and then reads one word
`ifndef CMAC_CTRL_TB_CASES_SVH
`define CMAC_CTRL_TB_CASES_SVH

task automatic load_cases();
    // nothing counted yet, every selector reads zero
    for (int s = 0; s < 12; s++) begin
        add_case("after_reset", '0, '0, 0, stat_sel_e'(s));
    end

    // receive totals
    add_case("rx_traffic_a", rx_of(1, 3, 1500, 100, 0, 0, 0, 0, 0), '0, 6, rx_good_pkts);
    add_case("rx_traffic_b", rx_of(0, 5, 9000, 127, 0, 0, 0, 0, 0), '0, 4, rx_total_pkts);
    add_case("rx_traffic_c", rx_of(1, 7, 16383, 64, 0, 0, 0, 0, 0), '0, 3, rx_good_bytes);
    add_case("rx_traffic_d", rx_of(1, 1, 64, 1, 0, 0, 0, 0, 0), '0, 10, rx_total_bytes);
    add_case("rx_pkts_sum", '0, '0, 0, rx_good_pkts);
    add_case("rx_total_sum", '0, '0, 0, rx_total_pkts);

    // error flags, multi-bit values still count once per cycle
    add_case("err_fcs_multi", rx_of(0, 0, 0, 0, 0, 0, 3, 1, 0), '0, 5, err_fcs_preamble);
    add_case("err_code_only", rx_of(0, 0, 0, 0, 0, 6, 0, 0, 0), '0, 4, err_align_code);
    add_case("err_align", rx_of(0, 0, 0, 0, 1, 7, 0, 0, 0), '0, 3, err_align_code);
    add_case("err_sfd", rx_of(0, 0, 0, 0, 0, 0, 0, 0, 1), '0, 9, err_sfd);
    add_case("err_fcs_mixed", rx_of(1, 2, 128, 60, 0, 0, 7, 0, 1), '0, 2, err_fcs_preamble);

    // transmit totals and fifo events
    add_case("tx_traffic_a", '0, tx_of(1, 1, 1024, 60, 0, 0), 8, tx_good_bytes);
    add_case("tx_traffic_b", '0, tx_of(0, 1, 0, 63, 1, 0), 5, tx_total_pkts);
    add_case("tx_ovf_unf", '0, tx_of(0, 0, 0, 0, 1, 1), 6, err_ovf_unf);
    add_case("tx_pkts_sum", '0, '0, 0, tx_good_pkts);
    add_case("tx_bytes_sum", '0, '0, 0, tx_total_bytes);
    add_case("both_sides", rx_of(1, 2, 512, 40, 0, 1, 0, 0, 0),
             tx_of(1, 1, 512, 40, 0, 1), 7, err_ovf_unf);
    add_case("rx_bytes_final", '0, '0, 0, rx_good_bytes);
    add_case("align_code_final", '0, '0, 0, err_align_code);
    add_case("sfd_final", '0, '0, 0, err_sfd);
endtask

`endif

// ==== dv/cmac_ctrl_tb.sv ====
// testbench for the 100G MAC user-side control
// checks bring-up timing edge by edge, then runs the statistics table
// through the readout port under random response back-pressure
`timescale 1ns/1ps

module cmac_ctrl_tb import cmac_link_pkg::*, cmac_stat_pkg::*; ();

    localparam int ALIGN_UP  = 5;    // first edge that sees alignment
    localparam int ALIGN_DN  = 10;   // first edge that sees it lost
    localparam int LAST_EDGE = 15;

    typedef struct {
        string      name;
        rx_stat_t   rx;
        tx_stat_t   tx;
        int         reps;
        stat_sel_e  sel;
        stat_word_u exp;
    } case_t;

    logic       gt_txusrclk2;
    logic       usr_rx_reset_w;
    logic       stat_rx_aligned;
    rx_stat_t   rx_stat;
    tx_stat_t   tx_stat;
    mac_ctl_t   mac_ctl;
    logic       req_valid;
    stat_sel_e  req_sel;
    logic       req_ready;
    logic       rsp_valid;
    stat_word_u rsp_word;
    logic       rsp_ready;

    case_t cases[$];
    int    cycles;
    int    cycle_limit;
    int    n_tests;
    int    n_failed;
    int    n_checks;
    int    n_errors;
    int    test_errs;

    cmac_ctrl_top i_cmac_ctrl_top (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .rx_stat         (rx_stat),
        .tx_stat         (tx_stat),
        .mac_ctl         (mac_ctl),
        .req_valid       (req_valid),
        .req_sel         (req_sel),
        .req_ready       (req_ready),
        .rsp_valid       (rsp_valid),
        .rsp_word        (rsp_word),
        .rsp_ready       (rsp_ready)
    );

    initial begin
        gt_txusrclk2 = 1'b0;
        forever #10 gt_txusrclk2 = ~gt_txusrclk2;
    end

    function automatic rx_stat_t rx_of(input int gp, input int tp, input int gb, input int tb,
                                       input int al, input int code, input int fcs,
                                       input int pre, input int sfd);
        rx_stat_t r;
        r.good_packets  = 1'(gp);
        r.total_packets = 3'(tp);
        r.good_bytes    = 14'(gb);
        r.total_bytes   = 7'(tb);
        r.aligned_err   = 1'(al);
        r.bad_code      = 3'(code);
        r.bad_fcs       = 3'(fcs);
        r.bad_preamble  = 1'(pre);
        r.bad_sfd       = 1'(sfd);
        return r;
    endfunction

    function automatic tx_stat_t tx_of(input int gp, input int tp, input int gb, input int tb,
                                       input int ovf, input int unf);
        tx_stat_t t;
        t.good_packets  = 1'(gp);
        t.total_packets = 1'(tp);
        t.good_bytes    = 14'(gb);
        t.total_bytes   = 6'(tb);
        t.ovf           = 1'(ovf);
        t.unf           = 1'(unf);
        return t;
    endfunction

    task automatic add_case(input string name, input rx_stat_t rx, input tx_stat_t tx,
                            input int reps, input stat_sel_e sel);
        case_t c;
        c.name = name;
        c.rx   = rx;
        c.tx   = tx;
        c.reps = reps;
        c.sel  = sel;
        c.exp  = '0;
        cases.push_back(c);
    endtask

    `include "cmac_ctrl_tb_cases.svh"

    // an error counter moves once per cycle its flag is nonzero
    function automatic int cycles_if_set(input logic [2:0] field, input int reps);
        return (field != 3'd0) ? reps : 0;
    endfunction

    // running sums over the table, entry i includes itself
    task automatic fill_expected();
        logic [CNT_W-1:0] tot [8];
        logic [ERR_W-1:0] ev [7];
        stat_word_u       w;
        foreach (tot[k]) tot[k] = '0;
        foreach (ev[k]) ev[k] = '0;
        foreach (cases[i]) begin
            tot[0] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].rx.good_packets);
            tot[1] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].rx.total_packets);
            tot[2] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].rx.good_bytes);
            tot[3] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].rx.total_bytes);
            tot[4] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].tx.good_packets);
            tot[5] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].tx.total_packets);
            tot[6] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].tx.good_bytes);
            tot[7] += CNT_W'(cases[i].reps) * CNT_W'(cases[i].tx.total_bytes);
            ev[0] += ERR_W'(cycles_if_set(3'(cases[i].rx.aligned_err), cases[i].reps));
            ev[1] += ERR_W'(cycles_if_set(cases[i].rx.bad_code, cases[i].reps));
            ev[2] += ERR_W'(cycles_if_set(cases[i].rx.bad_fcs, cases[i].reps));
            ev[3] += ERR_W'(cycles_if_set(3'(cases[i].rx.bad_preamble), cases[i].reps));
            ev[4] += ERR_W'(cycles_if_set(3'(cases[i].rx.bad_sfd), cases[i].reps));
            ev[5] += ERR_W'(cycles_if_set(3'(cases[i].tx.ovf), cases[i].reps));
            ev[6] += ERR_W'(cycles_if_set(3'(cases[i].tx.unf), cases[i].reps));
            w = '0;
            case (cases[i].sel)
                err_align_code: begin
                    w.errs.hi = ev[0];
                    w.errs.lo = ev[1];
                end
                err_fcs_preamble: begin
                    w.errs.hi = ev[2];
                    w.errs.lo = ev[3];
                end
                err_sfd:     w.errs.hi = ev[4];   // lo stays zero
                err_ovf_unf: begin
                    w.errs.hi = ev[5];
                    w.errs.lo = ev[6];
                end
                default:     w.count = tot[int'(cases[i].sel)];
            endcase
            cases[i].exp = w;
        end
    endtask

    task automatic check_ctl(input string name, input mac_ctl_t exp, input mac_ctl_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errs++;
            $display("[ERROR] %s: expected mac_ctl %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input stat_word_u exp, input stat_word_u act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errs++;
            $display("[ERROR] %s: expected %h (hi %0d lo %0d), actual %h (hi %0d lo %0d)",
                     name, exp.count, exp.errs.hi, exp.errs.lo,
                     act.count, act.errs.hi, act.errs.lo);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errs++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (test_errs == 0) begin
            $display("[PASS] %s", name);
        end else begin
            n_failed++;
            $display("[FAIL] %s (%0d errors)", name, test_errs);
        end
        test_errs = 0;
    endtask

    // control word the bring-up timing calls for after edge e
    function automatic mac_ctl_t expected_ctl(input int e);
        mac_ctl_t c;
        c = '0;
        if ((e >= 2 && e < ALIGN_UP + 2) || e >= ALIGN_DN + 3) begin
            c.rx_enable   = 1'b1;
            c.tx_send_lfi = 1'b1;
            c.tx_send_rfi = 1'b1;
        end else if (e >= ALIGN_UP + 2 && e < ALIGN_DN + 2) begin
            c.rx_enable = 1'b1;
            c.tx_enable = 1'b1;
        end
        return c;
    endfunction

    task automatic run_edges(input string name, input int first, input int last);
        for (int e = first; e <= last; e++) begin
            @(posedge gt_txusrclk2);
            stat_rx_aligned <= (e + 1 >= ALIGN_UP) && (e + 1 < ALIGN_DN);   // seen at e+1
            @(negedge gt_txusrclk2);
            check_ctl($sformatf("%s edge %0d", name, e), expected_ctl(e), mac_ctl);
        end
    endtask

    task automatic read_word(input string name, input stat_sel_e sel, input stat_word_u exp);
        stat_word_u held;
        logic       taken;
        @(posedge gt_txusrclk2);
        req_valid <= 1'b1;
        req_sel   <= sel;
        do begin
            @(negedge gt_txusrclk2);
            taken = req_ready;   // accepted at the coming edge
            @(posedge gt_txusrclk2);
        end while (!taken);
        req_valid <= 1'b0;
        @(negedge gt_txusrclk2);
        check_flag($sformatf("%s rsp_valid one cycle after accept", name), 1'b1, rsp_valid);
        check_word(name, exp, rsp_word);
        held = rsp_word;
        while (!rsp_ready) begin
            check_flag($sformatf("%s req_ready while pending", name), 1'b0, req_ready);
            @(negedge gt_txusrclk2);
            check_flag($sformatf("%s rsp_valid held", name), 1'b1, rsp_valid);
            check_word($sformatf("%s hold", name), held, rsp_word);
        end
        check_flag($sformatf("%s req_ready while pending", name), 1'b0, req_ready);
        @(posedge gt_txusrclk2);   // response taken here
        @(negedge gt_txusrclk2);
        check_flag($sformatf("%s req_ready after transfer", name), 1'b1, req_ready);
    endtask

    // response back-pressure
    initial begin
        void'($urandom(32'h0496_3869));
        rsp_ready = 1'b0;
        forever begin
            @(posedge gt_txusrclk2);
            rsp_ready <= ($urandom % 3) == 0;   // ready about one cycle in three
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge gt_txusrclk2);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        usr_rx_reset_w  = 1'b1;
        stat_rx_aligned = 1'b0;
        rx_stat         = '0;
        tx_stat         = '0;
        req_valid       = 1'b0;
        req_sel         = rx_good_pkts;
        load_cases();
        fill_expected();
        cycle_limit = 50;
        foreach (cases[i]) cycle_limit += cases[i].reps + 40;

        repeat (7) @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        check_ctl("reset mac_ctl", '0, mac_ctl);
        check_flag("reset req_ready", 1'b1, req_ready);
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        @(posedge gt_txusrclk2);
        usr_rx_reset_w <= 1'b0;   // next edge is edge 0
        end_test("reset");

        run_edges("bringup", 0, ALIGN_DN - 1);
        end_test("bringup");
        run_edges("align_loss", ALIGN_DN, LAST_EDGE);
        end_test("align_loss");

        foreach (cases[i]) begin
            repeat (cases[i].reps) begin
                @(posedge gt_txusrclk2);
                rx_stat <= cases[i].rx;
                tx_stat <= cases[i].tx;
            end
            @(posedge gt_txusrclk2);
            rx_stat <= '0;
            tx_stat <= '0;
            @(posedge gt_txusrclk2);   // second idle cycle
            read_word(cases[i].name, cases[i].sel, cases[i].exp);
            end_test($sformatf("%s %s", cases[i].name, cases[i].sel.name()));
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+dv
logic/cmac_link_pkg.sv
logic/cmac_stat_pkg.sv
logic/link_bringup.sv
logic/rx_stat_accum.sv
logic/tx_stat_accum.sv
logic/stat_readout.sv
logic/cmac_ctrl_top.sv
dv/cmac_ctrl_tb.sv
